// File: verilog/bus_macros.svh
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

////////////////////////////////////////////////////////////
// program ram size, log2 of the word count
////////////////////////////////////////////////////////////

`define RAM_ADDR_BITS 10

////////////////////////////////////////////////////////////
// address map, top nibble of the byte address
////////////////////////////////////////////////////////////

`define REGION_RAM_BASE_NIBBLE   4'h0
`define REGION_DEBUG_BASE_NIBBLE 4'h1

`define DEBUG_DISPLAY_WORD 2'd0 // display value, read and write
`define DEBUG_CYCLES_WORD  2'd1 // cycle counter, read only

// each digit stays lit for 2**SEG_DIV_BITS cycles
`define SEG_DIV_BITS 4

`endif

// File: verilog/bus_pkg.sv
`include "bus_macros.svh"

package bus_pkg;

    // one data word on the cpu bus
    typedef logic [31:0] bus_word_t;

    // one enable per byte lane, all zero is a plain read
    typedef logic [3:0] byte_strobe_t;

    // regions that have a slave behind them
    typedef enum logic [3:0] {
        region_ram   = `REGION_RAM_BASE_NIBBLE,
        region_debug = `REGION_DEBUG_BASE_NIBBLE
    } region_e;

    // byte address, seen either whole or split into its fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [3:0]  region;   // selects the slave
            logic [25:0] word;     // word offset inside the region
            logic [1:0]  byte_sel; // lane within the word
        } fields;
    } bus_addr_u;

    // cathodes, active low, segment a in bit 0
    typedef logic [6:0] seg_t;

endpackage

// File: verilog/memory_controller.sv
`include "bus_macros.svh"

module memory_controller (
    input  logic                      clk_100mhz,
    input  logic                      rst_n,

    // processor data port
    input  bus_pkg::bus_addr_u        cpu_addr,
    input  bus_pkg::bus_word_t        cpu_wdata,
    input  bus_pkg::byte_strobe_t     cpu_we,
    output bus_pkg::bus_word_t        cpu_rdata,

    // program ram
    output logic [`RAM_ADDR_BITS-1:0] ram_addr,
    output bus_pkg::bus_word_t        ram_wdata,
    output bus_pkg::byte_strobe_t     ram_we,
    input  bus_pkg::bus_word_t        ram_rdata,

    // debug registers
    output logic [1:0]                dbg_word,
    output bus_pkg::bus_word_t        dbg_wdata,
    output bus_pkg::byte_strobe_t     dbg_we,
    input  bus_pkg::bus_word_t        dbg_rdata
);
    import bus_pkg::*;

    // parked here in reset so the first read returns zero
    localparam logic [3:0] region_none = 4'hf;

    logic [3:0] region;    // region of this cycle's address
    logic [3:0] rd_region; // region of last cycle's address
    logic       sel_ram;
    logic       sel_dbg;

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////

    assign region  = cpu_addr.fields.region;
    assign sel_ram = (region == region_ram);
    assign sel_dbg = (region == region_debug);

    // address and data go to both slaves, only strobes are steered
    assign ram_addr  = cpu_addr.fields.word[`RAM_ADDR_BITS-1:0]; // upper offset bits alias
    assign ram_wdata = cpu_wdata;
    assign ram_we    = sel_ram ? cpu_we : '0;

    assign dbg_word  = cpu_addr.fields.word[1:0];
    assign dbg_wdata = cpu_wdata;
    assign dbg_we    = sel_dbg ? cpu_we : '0;

    ////////////////////////////////////////////////////////////
    // read return
    ////////////////////////////////////////////////////////////

    // both slaves answer one cycle late, so the select follows
    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            rd_region <= region_none;
        end else begin
            rd_region <= region;
        end
    end

    always_comb begin
        case (rd_region)
            region_ram:   cpu_rdata = ram_rdata;
            region_debug: cpu_rdata = dbg_rdata;
            default:      cpu_rdata = '0; // unmapped
        endcase
    end

endmodule

// File: verilog/program_ram.sv
`include "bus_macros.svh"

module program_ram #(
    parameter int addr_bits = `RAM_ADDR_BITS
) (
    input  logic                  clk_100mhz,
    input  logic [addr_bits-1:0]  addr,   // word index
    input  bus_pkg::bus_word_t    wdata,
    input  bus_pkg::byte_strobe_t we,
    output bus_pkg::bus_word_t    rdata
);
    import bus_pkg::*;

    localparam int depth = 1 << addr_bits;

    bus_word_t mem [depth];

    ////////////////////////////////////////////////////////////
    // byte lane write, write-first read
    ////////////////////////////////////////////////////////////

    // same address in the same cycle hands back the new bytes
    always_ff @(posedge clk_100mhz) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (we[lane]) begin
                mem[addr][8*lane +: 8] <= wdata[8*lane +: 8];
                rdata[8*lane +: 8]     <= wdata[8*lane +: 8];
            end else begin
                rdata[8*lane +: 8]     <= mem[addr][8*lane +: 8]; // old byte kept
            end
        end
    end

endmodule

// File: verilog/debug_regs.sv
`include "bus_macros.svh"

module debug_regs (
    input  logic                  clk_100mhz,
    input  logic                  rst_n,
    input  logic [1:0]            word,          // register offset
    input  bus_pkg::bus_word_t    wdata,
    input  bus_pkg::byte_strobe_t we,
    output bus_pkg::bus_word_t    rdata,
    output bus_pkg::bus_word_t    display_value
);
    import bus_pkg::*;

    bus_word_t display_next; // display value after this cycle's write
    bus_word_t cycles;       // free running, not writable

    ////////////////////////////////////////////////////////////
    // display register
    ////////////////////////////////////////////////////////////

    always_comb begin
        display_next = display_value;
        for (int lane = 0; lane < 4; lane++) begin
            if (word == `DEBUG_DISPLAY_WORD && we[lane]) begin
                display_next[8*lane +: 8] = wdata[8*lane +: 8];
            end
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            display_value <= '0;
            cycles        <= '0;
        end else begin
            display_value <= display_next;
            cycles        <= cycles + 32'd1; // writes to this offset are dropped
        end
    end

    ////////////////////////////////////////////////////////////
    // registered read
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_100mhz) begin
        case (word)
            `DEBUG_DISPLAY_WORD: rdata <= display_next; // write-first like the ram
            `DEBUG_CYCLES_WORD:  rdata <= cycles;       // count at the addressed cycle
            default:             rdata <= '0;
        endcase
    end

endmodule

// File: verilog/seven_segment_controller.sv
`include "bus_macros.svh"

module seven_segment_controller #(
    parameter int div_bits = `SEG_DIV_BITS
) (
    input  logic               clk_100mhz,
    input  logic               rst_n,
    input  bus_pkg::bus_word_t value,
    output logic [7:0]         an,   // active low, one digit at a time
    output bus_pkg::seg_t      cat
);
    import bus_pkg::*;

    logic [div_bits+2:0] scan_count; // refresh divider with digit index on top
    logic [2:0]          digit;
    logic [3:0]          nibble;
    logic [6:0]          seg_on;     // lit segments, gfedcba

    ////////////////////////////////////////////////////////////
    // digit scan
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            scan_count <= '0; // starts on digit 0
        end else begin
            scan_count <= scan_count + 1'b1;
        end
    end

    assign digit  = scan_count[div_bits +: 3];
    assign nibble = value[4*digit +: 4];

    assign an = ~(8'b1 << digit);

    ////////////////////////////////////////////////////////////
    // hex to segment
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (nibble)
            4'h0: seg_on = 7'b011_1111;
            4'h1: seg_on = 7'b000_0110;
            4'h2: seg_on = 7'b101_1011;
            4'h3: seg_on = 7'b100_1111;
            4'h4: seg_on = 7'b110_0110;
            4'h5: seg_on = 7'b110_1101;
            4'h6: seg_on = 7'b111_1101;
            4'h7: seg_on = 7'b000_0111;
            4'h8: seg_on = 7'b111_1111;
            4'h9: seg_on = 7'b110_1111;
            4'ha: seg_on = 7'b111_0111;
            4'hb: seg_on = 7'b111_1100; // lower case b
            4'hc: seg_on = 7'b011_1001;
            4'hd: seg_on = 7'b101_1110; // lower case d
            4'he: seg_on = 7'b111_1001;
            default: seg_on = 7'b111_0001; // F
        endcase
    end

    // cathodes sink current, so a lit segment is a 0
    assign cat = ~seg_on;

endmodule

// File: verilog/top_level.sv
`include "bus_macros.svh"

module top_level (
    input  logic                  clk_100mhz,
    input  logic                  rst_n,
    input  bus_pkg::bus_addr_u    cpu_addr,
    input  bus_pkg::bus_word_t    cpu_wdata,
    input  bus_pkg::byte_strobe_t cpu_we,
    output bus_pkg::bus_word_t    cpu_rdata,
    output logic [3:0]            ss0_an,    // upper four digits
    output logic [3:0]            ss1_an,    // lower four digits
    output bus_pkg::seg_t         ss_c       // shared by both groups
);
    import bus_pkg::*;

    // ram side of the controller
    logic [`RAM_ADDR_BITS-1:0] ram_addr;
    bus_word_t                 ram_wdata;
    byte_strobe_t              ram_we;
    bus_word_t                 ram_rdata;

    // debug register side
    logic [1:0]   dbg_word;
    bus_word_t    dbg_wdata;
    byte_strobe_t dbg_we;
    bus_word_t    dbg_rdata;

    bus_word_t display_value;

    ////////////////////////////////////////////////////////////
    // memory and peripherals
    ////////////////////////////////////////////////////////////

    memory_controller memory_ctrl (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_we     (cpu_we),
        .cpu_rdata  (cpu_rdata),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_we     (ram_we),
        .ram_rdata  (ram_rdata),
        .dbg_word   (dbg_word),
        .dbg_wdata  (dbg_wdata),
        .dbg_we     (dbg_we),
        .dbg_rdata  (dbg_rdata)
    );

    program_ram #(
        .addr_bits (`RAM_ADDR_BITS)
    ) data_memory (
        .clk_100mhz (clk_100mhz),
        .addr       (ram_addr),
        .wdata      (ram_wdata),
        .we         (ram_we),
        .rdata      (ram_rdata)
    );

    debug_regs dbg_regs (
        .clk_100mhz    (clk_100mhz),
        .rst_n         (rst_n),
        .word          (dbg_word),
        .wdata         (dbg_wdata),
        .we            (dbg_we),
        .rdata         (dbg_rdata),
        .display_value (display_value)
    );

    ////////////////////////////////////////////////////////////
    // seven segment display
    ////////////////////////////////////////////////////////////

    seven_segment_controller mssc (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .value      (display_value),
        .an         ({ss0_an, ss1_an}), // digit 7 ends up on ss0_an[3]
        .cat        (ss_c)
    );

endmodule

// File: tests/top_level_asserts.sv
module top_level_asserts (
    input logic                  clk_100mhz,
    input logic                  rst_n,
    input bus_pkg::bus_addr_u    cpu_addr,
    input bus_pkg::byte_strobe_t ram_we,
    input bus_pkg::byte_strobe_t dbg_we,
    input bus_pkg::bus_word_t    cpu_rdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import bus_pkg::*;

    logic unmapped; // no slave behind this cycle's address
    int   failures = 0; // failed assertions, read by the testbench

    assign unmapped = (cpu_addr.fields.region != region_ram) &&
                      (cpu_addr.fields.region != region_debug);

    // strobes go to at most one slave
    one_slave_written: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        !(ram_we != '0 && dbg_we != '0))
        else begin
            failures++;
            $error("ram and debug strobes active in the same cycle");
        end

    no_unmapped_write: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        unmapped |-> (ram_we == '0 && dbg_we == '0))
        else begin
            failures++;
            $error("write strobe reached a slave for an unmapped address");
        end

    unmapped_reads_zero: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        unmapped |=> (cpu_rdata == '0))
        else begin
            failures++;
            $error("unmapped read returned nonzero data");
        end

endmodule

bind memory_controller top_level_asserts controller_asserts (.*);

// File: tests/tb_top_level.sv
`include "bus_macros.svh"

module tb_top_level;
    timeunit 1ns;
    timeprecision 1ps;
    import bus_pkg::*;

    localparam int random_count = 64;
    localparam int scan_cycles  = 8 * (1 << `SEG_DIV_BITS);
    localparam int ram_words    = 1 << `RAM_ADDR_BITS;
    localparam bus_word_t idle_addr   = 32'hf000_0000; // unmapped, reads back zero
    localparam bus_word_t cycles_addr =
        {`REGION_DEBUG_BASE_NIBBLE, 26'(`DEBUG_CYCLES_WORD), 2'b00};
    localparam bus_word_t disp_addr   =
        {`REGION_DEBUG_BASE_NIBBLE, 26'(`DEBUG_DISPLAY_WORD), 2'b00};

    logic         clk_100mhz;
    logic         rst_n;
    bus_addr_u    cpu_addr;
    bus_word_t    cpu_wdata;
    byte_strobe_t cpu_we;
    bus_word_t    cpu_rdata;
    logic [3:0]   ss0_an;
    logic [3:0]   ss1_an;
    seg_t         ss_c;

    // replayed vectors
    string        vec_name[$];
    string        vec_op[$];
    bus_word_t    vec_addr[$];
    bus_word_t    vec_data[$];
    byte_strobe_t vec_strobe[$];
    bus_word_t    vec_expected[$];

    bus_word_t ram_model [ram_words];
    int        rand_idx [random_count];
    logic [31:0] rng_state = 32'h9201173f;
    int        pass_count = 0;
    int        fail_count = 0;
    logic      vectors_loaded = 1'b0;

    top_level top_level_inst (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_we     (cpu_we),
        .cpu_rdata  (cpu_rdata),
        .ss0_an     (ss0_an),
        .ss1_an     (ss1_an),
        .ss_c       (ss_c)
    );

    initial begin
        clk_100mhz = 1'b0;
        forever #5 clk_100mhz = ~clk_100mhz;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // common anode codes, a in bit 0, lit segment is 0
    function automatic seg_t hex_segments(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    task automatic check_word(input string name, input bus_word_t expected,
                              input bus_word_t actual);
        if (actual === expected) begin
            pass_count++;
            $display("[ok] %s", name);
        end else begin
            fail_count++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_segments(input string name, input seg_t expected, input seg_t actual);
        if (actual === expected) begin
            pass_count++;
            $display("[ok] %s", name);
        end else begin
            fail_count++;
            $display("[ERROR] %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_increasing(input string name, input bus_word_t earlier,
                                    input bus_word_t later);
        if (later > earlier) begin
            pass_count++;
            $display("[ok] %s", name);
        end else begin
            fail_count++;
            $display("%s: cycle counter did not increase, %h then %h", name, earlier, later);
        end
    endtask

    // inputs change on the rising edge, the DUT takes them one edge later
    task automatic drive_bus(input bus_word_t addr, input bus_word_t wdata,
                             input byte_strobe_t we);
        @(posedge clk_100mhz);
        cpu_addr.raw <= addr;
        cpu_wdata    <= wdata;
        cpu_we       <= we;
    endtask

    task automatic read_bus(input bus_word_t addr, output bus_word_t rdata);
        drive_bus(addr, '0, '0);
        @(posedge clk_100mhz);
        @(negedge clk_100mhz); // rdata settled for the sampled address
        rdata = cpu_rdata;
    endtask

    task automatic load_vectors();
        int           fd;
        int           code;
        string        line;
        string        name;
        string        op;
        bus_word_t    addr;
        bus_word_t    data;
        bus_word_t    expected;
        byte_strobe_t strobe;
        fd = $fopen("tests/top_level_vectors.txt", "r");
        if (fd == 0) begin
            fail_count++;
            $display("could not open tests/top_level_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code <= 0 || line.len() < 2 || line[0] == "#") continue;
            code = $sscanf(line, "%s %s %h %h %h %h", name, op, addr, data, strobe, expected);
            if (code != 6) begin
                fail_count++;
                $display("malformed vector line: %s", line);
            end else begin
                vec_name.push_back(name);
                vec_op.push_back(op);
                vec_addr.push_back(addr);
                vec_data.push_back(data);
                vec_strobe.push_back(strobe);
                vec_expected.push_back(expected);
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // test phases
    ////////////////////////////////////////////////////////////

    task automatic replay_vectors();
        bus_word_t rd;
        foreach (vec_name[i]) begin
            if (vec_op[i] == "write") begin
                drive_bus(vec_addr[i], vec_data[i], vec_strobe[i]);
            end else if (vec_op[i] == "read") begin
                read_bus(vec_addr[i], rd);
                check_word(vec_name[i], vec_expected[i], rd);
            end else begin
                fail_count++;
                $display("%s: unknown operation %s", vec_name[i], vec_op[i]);
            end
        end
    endtask

    task automatic cycle_counter_test();
        bus_word_t first;
        bus_word_t second;
        bus_word_t third;
        read_bus(cycles_addr, first);
        repeat (16) @(posedge clk_100mhz);
        read_bus(cycles_addr, second);
        check_increasing("cycles_advance", first, second);
        drive_bus(cycles_addr, '0, 4'hf); // counter must ignore this
        read_bus(cycles_addr, third);
        check_increasing("cycles_write_ignored", second, third);
    endtask

    task automatic random_ram_test();
        bus_word_t data;
        bus_word_t rd;
        for (int i = 0; i < random_count; i++) begin
            rng_state   = xorshift(rng_state);
            rand_idx[i] = 16 + int'(rng_state % (ram_words - 16)); // clear of vector words
            rng_state   = xorshift(rng_state);
            data        = rng_state;
            ram_model[rand_idx[i]] = data;
            drive_bus(32'(rand_idx[i]) << 2, data, 4'hf);
        end
        for (int i = 0; i < random_count; i++) begin
            read_bus(32'(rand_idx[i]) << 2, rd);
            check_word($sformatf("random_%0d", i), ram_model[rand_idx[i]], rd);
        end
    endtask

    task automatic display_test(input bus_word_t shown);
        logic [7:0] an;
        logic [7:0] prev;
        int         changes;
        int         waited;
        int         digit;
        drive_bus(disp_addr, shown, 4'hf);
        drive_bus(idle_addr, '0, '0);
        repeat (scan_cycles) @(posedge clk_100mhz);
        @(negedge clk_100mhz);
        prev    = {ss0_an, ss1_an};
        changes = 0;
        waited  = 0;
        while (changes < 8 && waited < scan_cycles + (1 << `SEG_DIV_BITS)) begin
            @(negedge clk_100mhz);
            waited++;
            an = {ss0_an, ss1_an};
            if (an !== prev) begin
                changes++;
                prev = an;
                if ($countones(~an) != 1) begin
                    fail_count++;
                    $display("display: anodes %b do not have exactly one digit lit", an);
                end else begin
                    for (int k = 0; k < 8; k++) begin
                        if (!an[k]) begin
                            digit = k;
                        end
                    end
                    check_segments($sformatf("display_digit_%0d", digit),
                                   hex_segments(shown[4*digit +: 4]), ss_c);
                end
            end
        end
        if (changes < 8) begin
            fail_count++;
            $display("display: only %0d anode changes in %0d cycles", changes, waited);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        int assert_failures;
        rst_n        = 1'b0;
        cpu_addr.raw = '0; // unwritten ram word during reset
        cpu_wdata    = '0;
        cpu_we       = '0;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (10) @(posedge clk_100mhz);
        rst_n <= 1'b1;
        @(negedge clk_100mhz);
        check_word("reset_rdata", '0, cpu_rdata);
        replay_vectors();
        cycle_counter_test();
        random_ram_test();
        display_test(32'h4f2b_6c91);
        assert_failures = top_level_inst.memory_ctrl.controller_asserts.failures;
        if (assert_failures != 0) begin
            fail_count += assert_failures;
            $display("bound assertions failed %0d times", assert_failures);
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (vectors_loaded);
        limit = (vec_name.size() + random_count) * 4 + 2 * scan_cycles;
        repeat (limit) @(posedge clk_100mhz);
        $display("watchdog: run still going after %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: tests/top_level_vectors.txt
# name  op  address  data  strobe  expected
# numbers are hex, expected is compared on reads only
reset_display  read   10000000 00000000 0 00000000
ram_full_0     write  00000000 11223344 f 00000000
ram_full_1     write  00000004 a5a5a5a5 f 00000000
ram_full_0     read   00000000 00000000 0 11223344
ram_full_1     read   00000004 00000000 0 a5a5a5a5
ram_lane_0     write  00000000 000000ee 1 00000000
ram_lane_0     read   00000000 00000000 0 112233ee
ram_lane_32    write  00000000 cafe0000 c 00000000
ram_lane_32    read   00000000 00000000 0 cafe33ee
ram_lane_21    write  00000004 00beef00 6 00000000
ram_lane_21    read   00000004 00000000 0 a5beefa5
ram_lane_3     write  00000004 77000000 8 00000000
ram_lane_3     read   00000004 00000000 0 77beefa5
b2b_full       write  00000008 deadbeef f 00000000
b2b_full       read   00000008 00000000 0 deadbeef
b2b_partial    write  00000008 0000f00d 3 00000000
b2b_partial    read   00000008 00000000 0 deadf00d
unmap_2        write  20000000 ffffffff f 00000000
unmap_2        read   20000000 00000000 0 00000000
unmap_f        write  f0000004 12345678 f 00000000
unmap_f        read   f0000004 00000000 0 00000000
unmap_ram_0    read   00000000 00000000 0 cafe33ee
unmap_ram_1    read   00000004 00000000 0 77beefa5
disp_full      write  10000000 89abcdef f 00000000
disp_full      read   10000000 00000000 0 89abcdef
disp_lane_1    write  10000000 00005500 2 00000000
disp_lane_1    read   10000000 00000000 0 89ab55ef
unmap_disp     write  30000000 00000000 f 00000000
unmap_disp     read   10000000 00000000 0 89ab55ef
dbg_spare      read   10000008 00000000 0 00000000

// File: all.f
+incdir+verilog
verilog/bus_pkg.sv
verilog/memory_controller.sv
verilog/program_ram.sv
verilog/debug_regs.sv
verilog/seven_segment_controller.sv
verilog/top_level.sv
tests/top_level_asserts.sv
tests/tb_top_level.sv
